//--- laser_link.f
+incdir+verif
logic/link_proto_pkg.sv
logic/link_cfg_pkg.sv
logic/byte_fifo.sv
logic/marker_detector.sv
logic/link_config.sv
logic/link_sequencer.sv
logic/laser_link.sv
verif/laser_link_tb.sv

//--- verif/laser_link_tb_table.svh
`ifndef LASER_LINK_TB_TABLE_SVH
`define LASER_LINK_TB_TABLE_SVH

// Which side of the link opens the exchange
typedef enum logic [1:0] {
    SCN_TX,
    SCN_RX,
    SCN_RX_SILENT
} scn_kind_t;

// Columns: kind, random link_tx stalls, junk byte count, junk bytes before the marker,
// marker, payload count, payload bytes, expected count, expected bytes.
// For transmit rows the expected bytes are those seen on link_tx after each handshake,
// for receive rows they are the bytes that reach host_out.
typedef struct packed {
    scn_kind_t       kind;
    logic            stall;
    logic [3:0]      pre_len;
    logic [0:2][7:0] pre;
    marker_id_t      marker;
    logic [3:0]      pay_len;
    logic [0:7][7:0] payload;
    logic [3:0]      exp_len;
    logic [0:7][7:0] expected;
} scenario_t;

localparam int NUM_SCENARIOS = 5;

localparam scenario_t SCENARIOS [NUM_SCENARIOS] = '{
    // Three bytes out under random stalls
    '{SCN_TX, 1'b1, 4'd0, 24'h0, MARKER_START,
      4'd3, 64'h3c5a_e100_0000_0000, 4'd3, 64'h3c5a_e100_0000_0000},
    // Six bytes out, split over two frames
    '{SCN_TX, 1'b0, 4'd0, 24'h0, MARKER_START,
      4'd6, 64'h1122_3344_5566_0000, 4'd6, 64'h1122_3344_5566_0000},
    // Data marker, the last two payload bytes fall outside the frame
    '{SCN_RX, 1'b0, 4'd0, 24'h0, MARKER_DATA,
      4'd6, 64'h0123_4567_9e7f_0000, 4'd8, 64'hd1d2_d3d4_0123_4567},
    // Broken start marker then a stop marker
    '{SCN_RX, 1'b0, 4'd3, 24'hc1c2_00, MARKER_STOP,
      4'd4, 64'h0f1e_2d3c_0000_0000, 4'd8, 64'h5152_5354_0f1e_2d3c},
    // Handshake with no marker at all
    '{SCN_RX_SILENT, 1'b0, 4'd0, 24'h0, MARKER_START,
      4'd0, 64'h0, 4'd0, 64'h0}
};

`endif

//--- verif/laser_link_tb.sv
module laser_link_tb import link_proto_pkg::*, link_cfg_pkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [7:0] HS_CODE  = 8'hAA;
    localparam logic [7:0] ACK_CODE = 8'h10;

    // Link timing programmed before the scenarios run
    localparam int FRAME_LEN_CFG  = 4;
    localparam int RX_TIMEOUT_CFG = 40;
    localparam int ALIGN_CFG      = 8;
    localparam int GUARD_CFG      = 8;

    // Silence long enough for any frame or timeout to end
    localparam int SETTLE_CYCLES = RX_TIMEOUT_CFG + 8;
    // Sequencer copies the marker to the rx queue before taking payload
    localparam int MARKER_GAP    = 6;
    localparam int WAIT_LIMIT    = 200;

    typedef logic [0:3][7:0] marker_bytes_t;

    `include "laser_link_tb_table.svh"

    logic       clock;
    logic       reset;
    logic       host_in_valid;
    logic       host_in_ready;
    link_byte_t host_in_data;
    logic       host_out_valid;
    logic       host_out_ready;
    link_byte_t host_out_data;
    logic       link_tx_valid;
    logic       link_tx_ready;
    link_byte_t link_tx_data;
    logic       link_rx_valid;
    link_byte_t link_rx_data;
    logic       cfg_write;
    cfg_addr_t  cfg_addr;
    cfg_count_t cfg_wdata;
    logic       rx_overflow;

    integer seed;
    int     checks;
    int     errors;

    laser_link #(.FIFO_DEPTH(16)) uut (
        .clock          (clock),
        .reset          (reset),
        .host_in_valid  (host_in_valid),
        .host_in_ready  (host_in_ready),
        .host_in_data   (host_in_data),
        .host_out_valid (host_out_valid),
        .host_out_ready (host_out_ready),
        .host_out_data  (host_out_data),
        .link_tx_valid  (link_tx_valid),
        .link_tx_ready  (link_tx_ready),
        .link_tx_data   (link_tx_data),
        .link_rx_valid  (link_rx_valid),
        .link_rx_data   (link_rx_data),
        .cfg_write      (cfg_write),
        .cfg_addr       (cfg_addr),
        .cfg_wdata      (cfg_wdata),
        .rx_overflow    (rx_overflow)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Marker byte order as it goes on the wire
    function automatic marker_bytes_t marker_bytes(input marker_id_t id);
        case (id)
            MARKER_START: return 32'hc1c2c3c4;
            MARKER_DATA:  return 32'hd1d2d3d4;
            MARKER_STOP:  return 32'h51525354;
            MARKER_ERROR: return 32'hb1b2b3b4;
            default:      return 32'ha1a2a3a4;
        endcase
    endfunction

    task automatic report_and_finish();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
        errors++;
    endtask

    task automatic give_up(input string what);
        $display("Timeout at %0d ns: %s", $time, what);
        errors++;
        report_and_finish();
    endtask

    task automatic write_cfg(input cfg_addr_t addr, input cfg_count_t data);
        cfg_write <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clock);
        cfg_write <= 1'b0;
    endtask

    // Called on an edge; returns on the edge where the byte was taken
    task automatic push_host(input link_byte_t b);
        int   waited;
        logic taken;
        host_in_valid <= 1'b1;
        host_in_data  <= b;
        waited = 0;
        taken  = 1'b0;
        while (!taken) begin
            @(posedge clock);
            taken = host_in_ready;
            waited++;
            if (!taken && waited >= WAIT_LIMIT) begin
                give_up("host_in_ready stayed low");
            end
        end
    endtask

    task automatic send_rx(input link_byte_t b);
        link_rx_valid <= 1'b1;
        link_rx_data  <= b;
        @(posedge clock);
    endtask

    task automatic rx_quiet(input int cycles);
        link_rx_valid <= 1'b0;
        repeat (cycles) @(posedge clock);
    endtask

    // Remote receiver, optionally throttling link_tx_ready at random
    task automatic get_tx_byte(input logic stall, output link_byte_t b);
        int          waited;
        logic        got;
        logic [31:0] rnd;
        waited = 0;
        got    = 1'b0;
        b      = '0;
        while (!got) begin
            @(posedge clock);
            if (link_tx_valid && link_tx_ready) begin
                b   = link_tx_data;
                got = 1'b1;
            end
            if (stall) begin
                rnd = $random(seed);
                link_tx_ready <= rnd[0];
            end
            waited++;
            if (!got && waited >= WAIT_LIMIT) begin
                give_up("no byte accepted on link_tx");
            end
        end
    endtask

    task automatic push_all(input scenario_t row);
        for (int i = 0; i < row.pay_len; i++) begin
            push_host(row.payload[i]);
        end
        host_in_valid <= 1'b0;
    endtask

    // Handshake per frame, then at most one frame length of bytes
    task automatic serve_tx(input scenario_t row);
        int         sent;
        int         frame_left;
        link_byte_t b;
        sent = 0;
        while (sent < row.pay_len) begin
            get_tx_byte(row.stall, b);
            checks++;
            if (b != HS_CODE) begin
                report_mismatch("link_tx_data", HS_CODE, b);
            end
            send_rx(ACK_CODE);
            link_rx_valid <= 1'b0;
            frame_left = row.pay_len - sent;
            if (frame_left > FRAME_LEN_CFG) begin
                frame_left = FRAME_LEN_CFG;
            end
            repeat (frame_left) begin
                get_tx_byte(row.stall, b);
                checks++;
                if (b != row.expected[sent]) begin
                    report_mismatch("link_tx_data", row.expected[sent], b);
                end
                sent++;
            end
        end
    endtask

    task automatic handshake_in();
        link_byte_t b;
        send_rx(HS_CODE);
        link_rx_valid <= 1'b0;
        get_tx_byte(1'b0, b);
        checks++;
        if (b != ACK_CODE) begin
            report_mismatch("link_tx_data", ACK_CODE, b);
        end
    endtask

    // Drain host_out and make sure nothing follows the expected bytes
    task automatic take_host_bytes(input scenario_t row);
        int   waited;
        logic got;
        int   n;
        // Transmit rows expect nothing back on host_out
        n = (row.kind == SCN_TX) ? 0 : row.exp_len;
        host_out_ready <= 1'b1;
        for (int i = 0; i < n; i++) begin
            waited = 0;
            got    = 1'b0;
            while (!got) begin
                @(posedge clock);
                if (host_out_valid && host_out_ready) begin
                    got = 1'b1;
                    checks++;
                    if (host_out_data != row.expected[i]) begin
                        report_mismatch("host_out_data", row.expected[i], host_out_data);
                    end
                end
                waited++;
                if (!got && waited >= WAIT_LIMIT) begin
                    give_up("expected byte never reached host_out");
                end
            end
        end
        repeat (4) begin
            @(posedge clock);
            if (host_out_valid) begin
                $display("Unexpected byte %0h on host_out at %0d ns", host_out_data, $time);
                errors++;
            end
        end
        host_out_ready <= 1'b0;
    endtask

    task automatic run_scenario(input scenario_t row);
        marker_bytes_t mw;
        case (row.kind)
            SCN_TX: begin
                fork
                    push_all(row);
                    serve_tx(row);
                join
                link_tx_ready <= 1'b1;
            end
            SCN_RX: begin
                handshake_in();
                for (int i = 0; i < row.pre_len; i++) begin
                    send_rx(row.pre[i]);
                end
                mw = marker_bytes(row.marker);
                for (int i = 0; i < 4; i++) begin
                    send_rx(mw[i]);
                end
                rx_quiet(MARKER_GAP);
                for (int i = 0; i < row.pay_len; i++) begin
                    send_rx(row.payload[i]);
                end
            end
            default: begin
                // Silence must time out the marker wait before a new handshake
                handshake_in();
                rx_quiet(SETTLE_CYCLES);
                handshake_in();
            end
        endcase
        rx_quiet(SETTLE_CYCLES);
        take_host_bytes(row);
    endtask

    initial begin
        seed           = 32'h6173_5466;
        checks         = 0;
        errors         = 0;
        reset          = 1'b1;
        host_in_valid  = 1'b0;
        host_in_data   = '0;
        host_out_ready = 1'b0;
        link_tx_ready  = 1'b1;
        link_rx_valid  = 1'b0;
        link_rx_data   = '0;
        cfg_write      = 1'b0;
        cfg_addr       = '0;
        cfg_wdata      = '0;

        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);

        checks += 4;
        if (link_tx_valid !== 1'b0) begin
            report_mismatch("link_tx_valid", 0, link_tx_valid);
        end
        if (host_out_valid !== 1'b0) begin
            report_mismatch("host_out_valid", 0, host_out_valid);
        end
        if (rx_overflow !== 1'b0) begin
            report_mismatch("rx_overflow", 0, rx_overflow);
        end
        if (host_in_ready !== 1'b1) begin
            report_mismatch("host_in_ready", 1, host_in_ready);
        end

        write_cfg(CFG_FRAME_LEN, FRAME_LEN_CFG);
        write_cfg(CFG_RX_TIMEOUT, RX_TIMEOUT_CFG);
        write_cfg(CFG_ALIGN_WAIT, ALIGN_CFG);
        write_cfg(CFG_GUARD_WAIT, GUARD_CFG);
        @(posedge clock);

        for (int i = 0; i < NUM_SCENARIOS; i++) begin
            run_scenario(SCENARIOS[i]);
        end

        // No scenario fills the rx queue
        checks++;
        if (rx_overflow !== 1'b0) begin
            report_mismatch("rx_overflow", 0, rx_overflow);
        end
        report_and_finish();
    end

endmodule

//--- logic/laser_link.sv
module laser_link import link_proto_pkg::*, link_cfg_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       host_in_valid,
    output logic       host_in_ready,
    input  link_byte_t host_in_data,
    output logic       host_out_valid,
    input  logic       host_out_ready,
    output link_byte_t host_out_data,
    output logic       link_tx_valid,
    input  logic       link_tx_ready,
    output link_byte_t link_tx_data,
    input  logic       link_rx_valid,
    input  link_byte_t link_rx_data,
    input  logic       cfg_write,
    input  cfg_addr_t  cfg_addr,
    input  cfg_count_t cfg_wdata,
    output logic       rx_overflow
);

    logic       tx_q_valid, tx_q_ready;
    link_byte_t tx_q_data;
    logic       rx_q_valid, rx_q_ready;
    link_byte_t rx_q_data;
    logic       marker_hit;
    marker_id_t marker_id;
    cfg_count_t align_wait, guard_wait, rx_timeout, frame_len;

    // Host bytes waiting to go out on the link
    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_queue (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (host_in_valid),
        .in_ready  (host_in_ready),
        .in_data   (host_in_data),
        .out_valid (tx_q_valid),
        .out_ready (tx_q_ready),
        .out_data  (tx_q_data)
    );

    // Markers and payload on their way to the host
    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_queue (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (rx_q_valid),
        .in_ready  (rx_q_ready),
        .in_data   (rx_q_data),
        .out_valid (host_out_valid),
        .out_ready (host_out_ready),
        .out_data  (host_out_data)
    );

    marker_detector marker_det (
        .clock      (clock),
        .reset      (reset),
        .rx_valid   (link_rx_valid),
        .rx_data    (link_rx_data),
        .marker_hit (marker_hit),
        .marker_id  (marker_id)
    );

    link_config config_regs (
        .clock      (clock),
        .reset      (reset),
        .cfg_write  (cfg_write),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .align_wait (align_wait),
        .guard_wait (guard_wait),
        .rx_timeout (rx_timeout),
        .frame_len  (frame_len)
    );

    link_sequencer sequencer (
        .clock         (clock),
        .reset         (reset),
        .tx_q_valid    (tx_q_valid),
        .tx_q_ready    (tx_q_ready),
        .tx_q_data     (tx_q_data),
        .rx_q_valid    (rx_q_valid),
        .rx_q_ready    (rx_q_ready),
        .rx_q_data     (rx_q_data),
        .link_tx_valid (link_tx_valid),
        .link_tx_ready (link_tx_ready),
        .link_tx_data  (link_tx_data),
        .link_rx_valid (link_rx_valid),
        .link_rx_data  (link_rx_data),
        .marker_hit    (marker_hit),
        .marker_id     (marker_id),
        .align_wait    (align_wait),
        .guard_wait    (guard_wait),
        .rx_timeout    (rx_timeout),
        .frame_len     (frame_len),
        .rx_overflow   (rx_overflow)
    );

endmodule

//--- logic/link_sequencer.sv
module link_sequencer import link_proto_pkg::*, link_cfg_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       tx_q_valid,
    output logic       tx_q_ready,
    input  link_byte_t tx_q_data,
    output logic       rx_q_valid,
    input  logic       rx_q_ready,
    output link_byte_t rx_q_data,
    output logic       link_tx_valid,
    input  logic       link_tx_ready,
    output link_byte_t link_tx_data,
    input  logic       link_rx_valid,
    input  link_byte_t link_rx_data,
    input  logic       marker_hit,
    input  marker_id_t marker_id,
    input  cfg_count_t align_wait,
    input  cfg_count_t guard_wait,
    input  cfg_count_t rx_timeout,
    input  cfg_count_t frame_len,
    output logic       rx_overflow
);

    typedef enum logic [3:0] {
        ST_IDLE, ST_SEND_HS, ST_WAIT_ACK, ST_ALIGN, ST_SEND_BYTE, ST_GUARD,
        ST_SEND_ACK, ST_WAIT_MARKER, ST_WRITE_MARKER, ST_RX_PAYLOAD
    } seq_state_t;

    seq_state_t  state, state_n;
    cfg_count_t  gap_cnt, gap_n;
    cfg_count_t  frame_cnt, frame_n;
    logic [1:0]  mk_idx, mk_idx_n;
    marker_id_t  mk_id;
    marker_seq_t mk_seq;
    logic        overflow_n;
    logic        tx_load;
    link_byte_t  tx_load_data;
    logic        tx_slot_free;
    logic        hs_seen;
    logic        ack_seen;

    assign tx_slot_free = !link_tx_valid || link_tx_ready;
    assign hs_seen      = link_rx_valid && (link_rx_data == HS_BYTE);
    assign ack_seen     = link_rx_valid && (link_rx_data == HS_ACK_BYTE);
    assign mk_seq       = MARKER_SEQS[mk_id];

    always_comb begin
        state_n      = state;
        gap_n        = gap_cnt;
        frame_n      = frame_cnt;
        mk_idx_n     = mk_idx;
        overflow_n   = rx_overflow;
        tx_load      = 1'b0;
        tx_load_data = HS_BYTE;
        tx_q_ready   = 1'b0;
        rx_q_valid   = 1'b0;
        rx_q_data    = link_rx_data;

        case (state)
            ST_IDLE: begin
                // Outgoing data wins over a remote handshake
                if (tx_q_valid) begin
                    state_n = ST_SEND_HS;
                end else if (hs_seen) begin
                    state_n = ST_SEND_ACK;
                end
            end
            ST_SEND_HS: begin
                if (tx_slot_free) begin
                    tx_load = 1'b1;
                    gap_n   = '0;
                    state_n = ST_WAIT_ACK;
                end
            end
            ST_WAIT_ACK: begin
                if (ack_seen) begin
                    gap_n   = '0;
                    state_n = ST_ALIGN;
                end else if (gap_cnt >= rx_timeout) begin
                    state_n = ST_IDLE;
                end else if (!link_tx_valid) begin
                    gap_n = gap_cnt + 1'b1;
                end
            end
            ST_ALIGN: begin
                if (!link_tx_valid) begin
                    if (gap_cnt >= align_wait) begin
                        frame_n = '0;
                        state_n = ST_SEND_BYTE;
                    end else begin
                        gap_n = gap_cnt + 1'b1;
                    end
                end
            end
            ST_SEND_BYTE: begin
                // Frame ends early once the queue runs dry
                if (!tx_q_valid) begin
                    gap_n   = '0;
                    state_n = ST_GUARD;
                end else if (tx_slot_free) begin
                    tx_q_ready   = 1'b1;
                    tx_load      = 1'b1;
                    tx_load_data = tx_q_data;
                    frame_n      = frame_cnt + 1'b1;
                    if (frame_n == frame_len) begin
                        gap_n   = '0;
                        state_n = ST_GUARD;
                    end
                end
            end
            ST_GUARD: begin
                if (!link_tx_valid) begin
                    if (gap_cnt >= guard_wait) begin
                        state_n = ST_IDLE;
                    end else begin
                        gap_n = gap_cnt + 1'b1;
                    end
                end
            end
            ST_SEND_ACK: begin
                if (tx_slot_free) begin
                    tx_load      = 1'b1;
                    tx_load_data = HS_ACK_BYTE;
                    gap_n        = '0;
                    state_n      = ST_WAIT_MARKER;
                end
            end
            ST_WAIT_MARKER: begin
                if (marker_hit) begin
                    mk_idx_n = '0;
                    state_n  = ST_WRITE_MARKER;
                end else if (link_rx_valid) begin
                    gap_n = '0;
                end else if (gap_cnt >= rx_timeout) begin
                    state_n = ST_IDLE;
                end else if (!link_tx_valid) begin
                    gap_n = gap_cnt + 1'b1;
                end
            end
            ST_WRITE_MARKER: begin
                // Link bytes arriving in these four cycles are not captured
                rx_q_valid = 1'b1;
                rx_q_data  = mk_seq[2'd3 - mk_idx];
                if (rx_q_ready) begin
                    mk_idx_n = mk_idx + 1'b1;
                    if (mk_idx == 2'd3) begin
                        gap_n   = '0;
                        frame_n = '0;
                        state_n = ST_RX_PAYLOAD;
                    end
                end
            end
            ST_RX_PAYLOAD: begin
                if (link_rx_valid) begin
                    gap_n      = '0;
                    rx_q_valid = rx_q_ready;
                    if (!rx_q_ready) begin
                        overflow_n = 1'b1;
                    end
                    // Dropped bytes still count toward the frame
                    frame_n = frame_cnt + 1'b1;
                    if (frame_n == frame_len) begin
                        state_n = ST_IDLE;
                    end
                end else if (gap_cnt >= rx_timeout) begin
                    state_n = ST_IDLE;
                end else begin
                    gap_n = gap_cnt + 1'b1;
                end
            end
            default: state_n = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state         <= ST_IDLE;
            gap_cnt       <= '0;
            frame_cnt     <= '0;
            mk_idx        <= '0;
            rx_overflow   <= 1'b0;
            link_tx_valid <= 1'b0;
        end else begin
            state       <= state_n;
            gap_cnt     <= gap_n;
            frame_cnt   <= frame_n;
            mk_idx      <= mk_idx_n;
            rx_overflow <= overflow_n;
            if (tx_load) begin
                link_tx_valid <= 1'b1;
            end else if (link_tx_ready) begin
                link_tx_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (tx_load) begin
            link_tx_data <= tx_load_data;
        end
        if ((state == ST_WAIT_MARKER) && marker_hit) begin
            mk_id <= marker_id;
        end
    end

    a_tx_hold: assert property (@(posedge clock) disable iff (reset)
        link_tx_valid && !link_tx_ready |=> link_tx_valid && $stable(link_tx_data))
        else $error("link_tx_data changed while stalled");

endmodule

//--- logic/link_config.sv
module link_config import link_cfg_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       cfg_write,
    input  cfg_addr_t  cfg_addr,
    input  cfg_count_t cfg_wdata,
    output cfg_count_t align_wait,
    output cfg_count_t guard_wait,
    output cfg_count_t rx_timeout,
    output cfg_count_t frame_len
);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            align_wait <= ALIGN_WAIT_DEFAULT;
            guard_wait <= GUARD_WAIT_DEFAULT;
            rx_timeout <= RX_TIMEOUT_DEFAULT;
            frame_len  <= FRAME_LEN_DEFAULT;
        end else if (cfg_write) begin
            case (cfg_addr)
                CFG_ALIGN_WAIT: align_wait <= cfg_wdata;
                CFG_GUARD_WAIT: guard_wait <= cfg_wdata;
                CFG_RX_TIMEOUT: rx_timeout <= cfg_wdata;
                CFG_FRAME_LEN:  frame_len  <= cfg_wdata;
                default:        align_wait <= align_wait;
            endcase
        end
    end

    // Zero length frame would never end in the sequencer
    a_frame_len_nonzero: assert property (@(posedge clock) disable iff (reset)
        frame_len != '0)
        else $error("frame_len programmed to zero");

endmodule

//--- logic/marker_detector.sv
module marker_detector import link_proto_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       rx_valid,
    input  link_byte_t rx_data,
    output logic       marker_hit,
    output marker_id_t marker_id
);

    // Number of marker bytes matched so far, zero while waiting
    logic [1:0]  match_cnt;
    marker_id_t  cur_id;
    logic        first_hit;
    marker_id_t  first_id;
    marker_seq_t cur_seq;
    logic        next_match;

    // Which marker, if any, starts with this byte
    always_comb begin
        first_hit = 1'b0;
        first_id  = MARKER_START;
        for (int i = 0; i < NUM_MARKERS; i++) begin
            if (rx_data == MARKER_SEQS[i][3]) begin
                first_hit = 1'b1;
                first_id  = marker_id_t'(i);
            end
        end
    end

    assign cur_seq    = MARKER_SEQS[cur_id];
    assign next_match = (rx_data == cur_seq[2'd3 - match_cnt]);

    // Hit on the fourth byte itself
    assign marker_hit = rx_valid && (match_cnt == 2'd3) && next_match;
    assign marker_id  = cur_id;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            match_cnt <= '0;
            cur_id    <= MARKER_START;
        end else if (rx_valid) begin
            if (match_cnt == 2'd0) begin
                if (first_hit) begin
                    match_cnt <= 2'd1;
                    cur_id    <= first_id;
                end
            end else if (next_match && (match_cnt != 2'd3)) begin
                match_cnt <= match_cnt + 1'b1;
            end else begin
                // Mismatching byte is not tried as a new start
                match_cnt <= '0;
            end
        end
    end

    a_single_hit: assert property (@(posedge clock) disable iff (reset)
        marker_hit |=> !marker_hit)
        else $error("marker_hit held for two cycles");

endmodule

//--- logic/byte_fifo.sv
module byte_fifo import link_proto_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       in_valid,
    output logic       in_ready,
    input  link_byte_t in_data,
    output logic       out_valid,
    input  logic       out_ready,
    output link_byte_t out_data
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;

    link_byte_t       mem [FIFO_DEPTH];
    ptr_t             wr_ptr;
    ptr_t             rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Wrap at the depth, which need not be a power of two
    function automatic ptr_t next_ptr(ptr_t p);
        return (p == ptr_t'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready  = (count != FIFO_DEPTH);
    assign out_valid = (count != 0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Full queue keeps its write side parked until a pop frees a slot
    a_no_push_full: assert property (@(posedge clock) disable iff (reset)
        (count == FIFO_DEPTH) && !pop |=> $stable(wr_ptr) && (count == FIFO_DEPTH))
        else $error("byte_fifo written while full");

    a_no_pop_empty: assert property (@(posedge clock) disable iff (reset)
        (count == 0) && !push |=> $stable(rd_ptr) && !out_valid)
        else $error("byte_fifo read while empty");

endmodule

//--- logic/link_cfg_pkg.sv
package link_cfg_pkg;

    // Shared width of timing fields and sequencer counters
    localparam int CFG_WIDTH = 12;

    typedef logic [CFG_WIDTH-1:0] cfg_count_t;
    typedef logic [1:0]           cfg_addr_t;

    // Register map
    localparam cfg_addr_t CFG_ALIGN_WAIT = 2'd0;
    localparam cfg_addr_t CFG_GUARD_WAIT = 2'd1;
    localparam cfg_addr_t CFG_RX_TIMEOUT = 2'd2;
    localparam cfg_addr_t CFG_FRAME_LEN  = 2'd3;

    // Values after reset
    localparam cfg_count_t ALIGN_WAIT_DEFAULT = 12'd192;
    localparam cfg_count_t GUARD_WAIT_DEFAULT = 12'd256;
    localparam cfg_count_t RX_TIMEOUT_DEFAULT = 12'd1024;
    localparam cfg_count_t FRAME_LEN_DEFAULT  = 12'd1024;

endpackage

//--- logic/link_proto_pkg.sv
package link_proto_pkg;

    // One byte on the link or on either host queue
    typedef logic [7:0] link_byte_t;

    // Handshake codes
    localparam link_byte_t HS_BYTE     = 8'hAA;
    localparam link_byte_t HS_ACK_BYTE = 8'h10;

    // Marker kinds, also the index into MARKER_SEQS
    typedef enum logic [2:0] {
        MARKER_START,
        MARKER_DATA,
        MARKER_STOP,
        MARKER_ERROR,
        MARKER_DONE
    } marker_id_t;

    localparam int NUM_MARKERS = 5;

    // Byte 3 goes on the wire first
    typedef logic [3:0][7:0] marker_seq_t;

    // First bytes must stay pairwise distinct for the detector
    localparam marker_seq_t MARKER_SEQS [NUM_MARKERS] = '{
        32'hc1c2c3c4,
        32'hd1d2d3d4,
        32'h51525354,
        32'hb1b2b3b4,
        32'ha1a2a3a4
    };

endpackage
